/* sim/datapath_stimulus.txt */
# I <hex word> issues one instruction, G <n> idles n cycles, G ? idles a random 1 to 4
# E <reg, decimal> <hex value> expects a write-back from the instruction just above
I 34011234
E 1 00001234
I 3C028000
E 2 80000000
I 2423FFFF
E 3 00001233
I 00612021
E 4 00002467
I 00242823
E 5 FFFFEDCD
I 00A1302A
E 6 00000001
I 00A1382B
E 7 00000000
G 2
I 00A44024
E 8 00002445
I 00414825
E 9 80001234
I 01255026
E 10 7FFFFFF9
I 00225827
E 11 7FFFEDCB
I 00016100
E 12 00012340
I 00026A02
E 13 00800000
I 00027203
E 14 FF800000
G ?
I 30AFFFFF
E 15 0000EDCD
I 39F08000
E 16 00006DCD
I 28B1F000
E 17 00000001
G ?
I 2C32FFFF
E 18 00000001
# unknown opcode, unknown function code, write to r0: none of them retire a write
I FC221234
I 00229801
I 24200005
# r0 must still read zero right behind the suppressed write
I 00019821
E 19 00001234
G 1

/* filelist.f */
+incdir+common
common/core_pkg.sv
decode/instr_decoder.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
result/write_back.sv
logic/datapath.sv
sim/datapath_sva.sv
sim/datapath_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := datapath_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/datapath_tb.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module datapath_tb;

    localparam int          CLK_PERIOD    = 8;
    localparam int          RESET_CYCLES  = 2;
    localparam int          DRAIN_TIMEOUT = 50;    // cycles
    localparam int          QUIET_CYCLES  = 4;
    localparam int unsigned RANDOM_SEED   = 68403;
    localparam string       STIM_FILE     = "sim/datapath_stimulus.txt";

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    logic [`DATA_W-1:0]     instr;
    logic [`DATA_W-1:0]     debugWbPc;
    logic [3:0]             debugWbRfWen;
    logic [`REG_ADDR_W-1:0] debugWbRfWnum;
    logic [`DATA_W-1:0]     debugWbRfWdata;

    // expected write-backs in file order
    logic [`DATA_W-1:0]     expPcQ[$];
    logic [`REG_ADDR_W-1:0] expNumQ[$];
    logic [`DATA_W-1:0]     expDataQ[$];

    int valueErrors;
    int otherErrors;    // missing, unexpected or unreadable
    int checkedCount;
    int expectedCount;
    int issueCount;

    datapath dut_i (
        .clk_i           (clk),
        .rstN_i          (rstN),
        .instrValid_i    (instrValid),
        .instr_i         (instr),
        .debugWbPc_o     (debugWbPc),
        .debugWbRfWen_o  (debugWbRfWen),
        .debugWbRfWnum_o (debugWbRfWnum),
        .debugWbRfWdata_o(debugWbRfWdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // pc of the instruction with the given zero-based issue number
    function automatic logic [`DATA_W-1:0] pcOfIssue(input int index);
        return `RESET_PC + `PC_STEP * index;
    endfunction

    task automatic reportMismatch(
        input string              signalName,
        input logic [`DATA_W-1:0] expected,
        input logic [`DATA_W-1:0] actual
    );
        $display("Error at %0t: %s expected %h, actual %h", $time, signalName, expected, actual);
        valueErrors++;
    endtask

    task automatic checkWriteBack();
        logic [`DATA_W-1:0]     expPc;
        logic [`REG_ADDR_W-1:0] expNum;
        logic [`DATA_W-1:0]     expData;
        if (expPcQ.size() == 0) begin
            $display("Unexpected write-back at %0t of r%0d with %h, none was expected",
                     $time, debugWbRfWnum, debugWbRfWdata);
            otherErrors++;
        end else begin
            expPc   = expPcQ.pop_front();
            expNum  = expNumQ.pop_front();
            expData = expDataQ.pop_front();
            checkedCount++;
            if (debugWbRfWen != 4'hF)
                reportMismatch("debugWbRfWen_o", `DATA_W'(4'hF), `DATA_W'(debugWbRfWen));
            if (debugWbPc != expPc)
                reportMismatch("debugWbPc_o", expPc, debugWbPc);
            if (debugWbRfWnum != expNum)
                reportMismatch("debugWbRfWnum_o", `DATA_W'(expNum), `DATA_W'(debugWbRfWnum));
            if (debugWbRfWdata != expData)
                reportMismatch("debugWbRfWdata_o", expData, debugWbRfWdata);
        end
    endtask

    // outputs come from registers, so the pre-edge value is the one retiring
    always @(posedge clk) begin
        if (rstN && debugWbRfWen != 4'h0)
            checkWriteBack();
    end

    task automatic issueInstr(input logic [`DATA_W-1:0] word);
        @(negedge clk);
        instrValid = 1'b1;
        instr      = word;
        issueCount++;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(negedge clk);
            instrValid = 1'b0;
            instr      = '0;
        end
    endtask

    initial begin
        int                 fd;
        int                 gap;
        int                 regIdx;
        int                 waited;
        string              line;
        string              kind;
        string              arg;
        logic [`DATA_W-1:0] word;
        logic [`DATA_W-1:0] value;

        $timeformat(-9, 1, " ns", 0);
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        void'($urandom(RANDOM_SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            otherErrors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = "";
                void'($sscanf(line, "%s", kind));
                if (kind == "I") begin
                    void'($sscanf(line, "%s %h", kind, word));
                    issueInstr(word);
                end else if (kind == "G") begin
                    void'($sscanf(line, "%s %s", kind, arg));
                    if (arg == "?")
                        gap = 1 + int'($urandom % 4);   // open gap of 1 to 4 cycles
                    else
                        void'($sscanf(arg, "%d", gap));
                    idleCycles(gap);
                end else if (kind == "E") begin
                    void'($sscanf(line, "%s %d %h", kind, regIdx, value));
                    // belongs to the instruction issued just before
                    expPcQ.push_back(pcOfIssue(issueCount - 1));
                    expNumQ.push_back(regIdx[`REG_ADDR_W-1:0]);
                    expDataQ.push_back(value);
                    expectedCount++;
                end else if (kind.len() != 0 && kind.getc(0) != "#") begin
                    $display("Stimulus line not understood: %s", line);
                    otherErrors++;
                end
            end
            $fclose(fd);
        end
        idleCycles(1);

        waited = 0;
        while (expPcQ.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (expPcQ.size() != 0) begin
            $display("Timeout: %0d expected write-backs still missing after %0d cycles",
                     expPcQ.size(), DRAIN_TIMEOUT);
            otherErrors++;
        end
        repeat (QUIET_CYCLES) @(negedge clk);  // catch stray write-backs

        $display("Summary: %0d value errors, %0d other errors, %0d of %0d write-backs checked",
                 valueErrors, otherErrors, checkedCount, expectedCount);
        if (valueErrors == 0 && otherErrors == 0 && checkedCount == expectedCount) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim/datapath_sva.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module datapath_sva (
    input logic                   clk_i,
    input logic                   rstN_i,
    input logic [`DATA_W-1:0]     debugWbPc_i,
    input logic [3:0]             debugWbRfWen_i,
    input logic [`REG_ADDR_W-1:0] debugWbRfWnum_i
);

    logic [`DATA_W-1:0] lastPc;     // pc of the previous write-back
    logic               seenWb;
    logic [`DATA_W-1:0] pcDelta;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            lastPc <= '0;
            seenWb <= 1'b0;
        end else if (debugWbRfWen_i != 4'h0) begin
            lastPc <= debugWbPc_i;
            seenWb <= 1'b1;
        end
    end

    assign pcDelta = debugWbPc_i - lastPc;

    noZeroIndex: assert property (@(posedge clk_i) disable iff (!rstN_i)
        debugWbRfWen_i != 4'h0 |-> debugWbRfWnum_i != '0)
        else $error("write-back enable set for register 0");

    quietInReset: assert property (@(posedge clk_i)
        !rstN_i |-> debugWbRfWen_i == 4'h0)
        else $error("write-back enable set while reset is active");

    // bubbles and silent instructions leave gaps but never a backward step
    pcSteps: assert property (@(posedge clk_i) disable iff (!rstN_i)
        (debugWbRfWen_i != 4'h0 && seenWb) |-> (pcDelta != '0 && pcDelta % `PC_STEP == 0))
        else $error("write-back pc did not advance by a multiple of the pc step");

endmodule

bind datapath datapath_sva sva_i (
    .clk_i          (clk_i),
    .rstN_i         (rstN_i),
    .debugWbPc_i    (debugWbPc_o),
    .debugWbRfWen_i (debugWbRfWen_o),
    .debugWbRfWnum_i(debugWbRfWnum_o)
);

/* logic/datapath.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module datapath
    import core_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstN_i,
    input  logic                   instrValid_i,
    input  logic [`DATA_W-1:0]     instr_i,
    output logic [`DATA_W-1:0]     debugWbPc_o,
    output logic [3:0]             debugWbRfWen_o,
    output logic [`REG_ADDR_W-1:0] debugWbRfWnum_o,
    output logic [`DATA_W-1:0]     debugWbRfWdata_o
);

    decodedT  decoded;
    executedT executed;
    regWriteT regWrite;     // fed back to the register file

    // fetch register, decode, register read
    decode_stage decode_i (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .instrValid_i(instrValid_i),
        .instr_i     (instr_i),
        .regWrite_i  (regWrite),
        .decoded_o   (decoded)
    );

    execute_stage execute_i (
        .clk_i     (clk_i),
        .rstN_i    (rstN_i),
        .decoded_i (decoded),
        .executed_o(executed)
    );

    write_back writeBack_i (
        .executed_i      (executed),
        .regWrite_o      (regWrite),
        .debugWbPc_o     (debugWbPc_o),
        .debugWbRfWen_o  (debugWbRfWen_o),
        .debugWbRfWnum_o (debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

endmodule

/* result/write_back.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module write_back
    import core_pkg::*;
(
    input  executedT               executed_i,
    output regWriteT               regWrite_o,
    output logic [`DATA_W-1:0]     debugWbPc_o,
    output logic [3:0]             debugWbRfWen_o,
    output logic [`REG_ADDR_W-1:0] debugWbRfWnum_o,
    output logic [`DATA_W-1:0]     debugWbRfWdata_o
);

    logic writeReq;

    assign writeReq = executed_i.valid & executed_i.writeEn;

    assign regWrite_o.enable = writeReq;
    assign regWrite_o.index  = executed_i.dest;
    assign regWrite_o.data   = executed_i.result;

    // byte enables all follow the single write strobe
    assign debugWbRfWen_o   = {4{writeReq}};
    assign debugWbPc_o      = executed_i.pc;
    assign debugWbRfWnum_o  = executed_i.dest;
    assign debugWbRfWdata_o = executed_i.result;

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage
    import core_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstN_i,
    input  decodedT decoded_i,
    output executedT executed_o
);

    logic [`DATA_W-1:0] srcA;
    logic [`DATA_W-1:0] rtValue;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluResult;
    executedT           executedD;

    // result still sitting in the execute register and not yet in the regfile
    function automatic logic [`DATA_W-1:0] bypass(
        input logic [`REG_ADDR_W-1:0] index,
        input logic [`DATA_W-1:0]     regData
    );
        if (executed_o.valid && executed_o.writeEn && executed_o.dest == index)
            return executed_o.result;
        return regData;
    endfunction

    assign srcA    = bypass(decoded_i.rs, decoded_i.rsData);
    assign rtValue = bypass(decoded_i.rt, decoded_i.rtData);
    assign srcB    = decoded_i.useImm ? decoded_i.immediate : rtValue;

    alu alu_i (
        .aluOp_i (decoded_i.aluOp),
        .srcA_i  (srcA),
        .srcB_i  (srcB),
        .shamt_i (decoded_i.shamt),
        .result_o(aluResult)
    );

    always_comb begin
        executedD.valid   = decoded_i.valid;
        executedD.pc      = decoded_i.pc;
        executedD.dest    = decoded_i.dest;
        executedD.writeEn = decoded_i.writeEn;
        executedD.result  = aluResult;
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            executed_o <= '0;
        end else begin
            executed_o <= executedD;
        end
    end

endmodule

/* execute/alu.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module alu
    import core_pkg::*;
(
    input  aluOpT                      aluOp_i,
    input  logic [`DATA_W-1:0]         srcA_i,
    input  logic [`DATA_W-1:0]         srcB_i,
    input  logic [$clog2(`DATA_W)-1:0] shamt_i,
    output logic [`DATA_W-1:0]         result_o
);

    localparam int HALF_W = `DATA_W / 2;

    logic signedLess;
    logic unsignedLess;

    assign signedLess   = $signed(srcA_i) < $signed(srcB_i);
    assign unsignedLess = srcA_i < srcB_i;

    always_comb begin
        case (aluOp_i)
            ALU_ADDU: result_o = srcA_i + srcB_i;    // wraps without an overflow trap
            ALU_SUBU: result_o = srcA_i - srcB_i;
            ALU_AND:  result_o = srcA_i & srcB_i;
            ALU_OR:   result_o = srcA_i | srcB_i;
            ALU_XOR:  result_o = srcA_i ^ srcB_i;
            ALU_NOR:  result_o = ~(srcA_i | srcB_i);
            ALU_SLT:  result_o = {{(`DATA_W-1){1'b0}}, signedLess};
            ALU_SLTU: result_o = {{(`DATA_W-1){1'b0}}, unsignedLess};
            // shifts act on rt as the second operand
            ALU_SLL:  result_o = srcB_i << shamt_i;
            ALU_SRL:  result_o = srcB_i >> shamt_i;
            ALU_SRA:  result_o = $unsigned($signed(srcB_i) >>> shamt_i);
            ALU_LUI:  result_o = {srcB_i[HALF_W-1:0], {HALF_W{1'b0}}};
            default:  result_o = '0;
        endcase
    end

endmodule

/* decode/decode_stage.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_stage
    import core_pkg::*;
(
    input  logic               clk_i,
    input  logic               rstN_i,
    input  logic               instrValid_i,
    input  logic [`DATA_W-1:0] instr_i,
    input  regWriteT           regWrite_i,
    output decodedT            decoded_o
);

    logic [`DATA_W-1:0] pcQ;         // pc of the next accepted instruction
    logic [`DATA_W-1:0] fetchInstr;
    logic [`DATA_W-1:0] fetchPc;
    logic               fetchValid;
    decodedT            decodedD;

    // pc only moves when an instruction is taken in
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            pcQ        <= `RESET_PC;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= instrValid_i;
            if (instrValid_i) begin
                pcQ <= pcQ + `DATA_W'(`PC_STEP);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (instrValid_i) begin
            fetchInstr <= instr_i;
            fetchPc    <= pcQ;
        end
    end

    instr_decoder decoder_i (
        .instr_i    (fetchInstr),
        .aluOp_o    (decodedD.aluOp),
        .useImm_o   (decodedD.useImm),
        .immediate_o(decodedD.immediate),
        .shamt_o    (decodedD.shamt),
        .rs_o       (decodedD.rs),
        .rt_o       (decodedD.rt),
        .dest_o     (decodedD.dest),
        .writeEn_o  (decodedD.writeEn)
    );

    reg_file regFile_i (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .regWrite_i (regWrite_i),
        .readAddrA_i(decodedD.rs),
        .readAddrB_i(decodedD.rt),
        .readDataA_o(decodedD.rsData),
        .readDataB_o(decodedD.rtData)
    );

    assign decodedD.valid = fetchValid;
    assign decodedD.pc    = fetchPc;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            decoded_o <= '0;
        end else begin
            decoded_o <= decodedD;  // bubble carries valid low
        end
    end

endmodule

/* decode/reg_file.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file
    import core_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstN_i,
    input  regWriteT               regWrite_i,
    input  logic [`REG_ADDR_W-1:0] readAddrA_i,
    input  logic [`REG_ADDR_W-1:0] readAddrB_i,
    output logic [`DATA_W-1:0]     readDataA_o,
    output logic [`DATA_W-1:0]     readDataB_o
);

    logic [`DATA_W-1:0] regs [`REG_COUNT-1:1];  // no storage for $zero

    function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (regWrite_i.enable && regWrite_i.index == addr)
            return regWrite_i.data;  // same-cycle write shows through
        return regs[addr];
    endfunction

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (regWrite_i.enable && regWrite_i.index != '0) begin
            regs[regWrite_i.index] <= regWrite_i.data;
        end
    end

    assign readDataA_o = readPort(readAddrA_i);
    assign readDataB_o = readPort(readAddrB_i);

endmodule

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module instr_decoder
    import core_pkg::*;
(
    input  logic [`DATA_W-1:0]         instr_i,
    output aluOpT                      aluOp_o,
    output logic                       useImm_o,
    output logic [`DATA_W-1:0]         immediate_o,
    output logic [$clog2(`DATA_W)-1:0] shamt_o,
    output logic [`REG_ADDR_W-1:0]     rs_o,
    output logic [`REG_ADDR_W-1:0]     rt_o,
    output logic [`REG_ADDR_W-1:0]     dest_o,
    output logic                       writeEn_o
);

    // function field codes of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    opcodeT      opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic        known;     // inverse of the reserved-instruction flag
    logic        zeroExt;
    logic        rtDest;

    assign opcode  = opcodeT'(instr_i[31:26]);
    assign funct   = instr_i[5:0];
    assign imm     = instr_i[15:0];
    assign rs_o    = instr_i[25:21];
    assign rt_o    = instr_i[20:16];
    assign shamt_o = instr_i[10:6];

    always_comb begin
        aluOp_o  = ALU_ADDU;
        useImm_o = 1'b1;
        known    = 1'b1;
        zeroExt  = 1'b0;
        rtDest   = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                useImm_o = 1'b0;
                rtDest   = 1'b0;    // R-type writes rd
                case (funct)
                    FN_SLL:  aluOp_o = ALU_SLL;
                    FN_SRL:  aluOp_o = ALU_SRL;
                    FN_SRA:  aluOp_o = ALU_SRA;
                    FN_ADDU: aluOp_o = ALU_ADDU;
                    FN_SUBU: aluOp_o = ALU_SUBU;
                    FN_AND:  aluOp_o = ALU_AND;
                    FN_OR:   aluOp_o = ALU_OR;
                    FN_XOR:  aluOp_o = ALU_XOR;
                    FN_NOR:  aluOp_o = ALU_NOR;
                    FN_SLT:  aluOp_o = ALU_SLT;
                    FN_SLTU: aluOp_o = ALU_SLTU;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: aluOp_o = ALU_ADDU;
            OP_SLTI:  aluOp_o = ALU_SLT;
            OP_SLTIU: aluOp_o = ALU_SLTU;  // still sign extended
            OP_ANDI: begin
                aluOp_o = ALU_AND;
                zeroExt = 1'b1;
            end
            OP_ORI: begin
                aluOp_o = ALU_OR;
                zeroExt = 1'b1;
            end
            OP_XORI: begin
                aluOp_o = ALU_XOR;
                zeroExt = 1'b1;
            end
            OP_LUI:   aluOp_o = ALU_LUI;
            default:  known = 1'b0;
        endcase
    end

    assign immediate_o = zeroExt ? {{(`DATA_W-16){1'b0}}, imm} : {{(`DATA_W-16){imm[15]}}, imm};
    assign dest_o      = rtDest ? instr_i[20:16] : instr_i[15:11];

    // $zero is never written
    assign writeEn_o = known && (dest_o != '0);

endmodule

/* common/core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADDU, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI
    } aluOpT;

    // decode to execute register
    typedef struct packed {
        logic                          valid;
        logic [`DATA_W-1:0]            pc;
        aluOpT                         aluOp;
        logic                          useImm;
        logic [`DATA_W-1:0]            immediate;  // already extended
        logic [$clog2(`DATA_W)-1:0]    shamt;
        logic [`REG_ADDR_W-1:0]        rs;
        logic [`REG_ADDR_W-1:0]        rt;
        logic [`DATA_W-1:0]            rsData;
        logic [`DATA_W-1:0]            rtData;
        logic [`REG_ADDR_W-1:0]        dest;
        logic                          writeEn;
    } decodedT;

    // execute to result register
    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   writeEn;
        logic [`DATA_W-1:0]     result;
    } executedT;

    // write request back into the register file
    typedef struct packed {
        logic                   enable;
        logic [`REG_ADDR_W-1:0] index;
        logic [`DATA_W-1:0]     data;
    } regWriteT;

endpackage

/* common/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and instruction word width
`define DATA_W 32

// register index width and register count
`define REG_ADDR_W 5
`define REG_COUNT 32

// boot vector of the first instruction after reset
`define RESET_PC 32'hBFC0_0000

// byte step between consecutive accepted instructions
`define PC_STEP 4

`endif
